/* flist.f */
+incdir+source
source/ctrl_pkg.sv
source/ctrl_fsm.sv
source/hazard_detect.sv
source/operand_fwd.sv
source/core_ctrl.sv
testbench/tb_core_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core_ctrl testbench with verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --top-module tb_core_ctrl -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

/* source/core_ctrl.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module core_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    fetch_enable_i,
	input  logic                    instr_valid_i,
	input  logic                    id_ready_i,
	input  logic                    ex_valid_i,
	input  logic                    branch_taken_ex_i,
	input  ctrl_pkg::decode_info_t  dec_i,
	input  logic                    irq_i,
	input  logic                    irq_req_i,
	input  logic                    irq_sec_i,
	input  logic [`IRQ_ID_W-1:0]    irq_id_i,
	input  logic                    m_ie_i,
	input  logic                    u_ie_i,
	input  logic [1:0]              priv_lvl_i,
	input  ctrl_pkg::hazard_match_t match_i,
	input  ctrl_pkg::wb_state_t     wb_i,
	output logic                    instr_req_o,
	output logic                    is_decoding_o,
	output logic                    deassert_we_o,
	output logic                    halt_if_o,
	output logic                    halt_id_o,
	output logic                    pc_set_o,
	output ctrl_pkg::pc_mux_e       pc_mux_o,
	output ctrl_pkg::trap_ctrl_t    trap_o,
	output logic                    irq_ack_o,
	output logic [`IRQ_ID_W-1:0]    irq_id_o,
	output logic                    exc_kill_o,
	output logic                    load_stall_o,
	output logic                    jr_stall_o,
	output ctrl_pkg::fw_sels_t      fw_sel_o
);

	ctrl_fsm i_ctrl_fsm (
		.clk, .rst_n, .fetch_enable_i, .instr_valid_i, .id_ready_i, .ex_valid_i,
		.branch_taken_ex_i, .dec_i, .irq_i, .irq_req_i, .irq_sec_i, .irq_id_i,
		.m_ie_i, .u_ie_i, .priv_lvl_i,
		.load_stall_i(load_stall_o), // stalls fold into deassert_we.
		.jr_stall_i(jr_stall_o),
		.instr_req_o, .is_decoding_o, .deassert_we_o, .halt_if_o, .halt_id_o,
		.pc_set_o, .pc_mux_o, .trap_o, .irq_ack_o, .irq_id_o, .exc_kill_o
	);

	hazard_detect i_hazard_detect (
		.is_decoding_i(is_decoding_o),
		.jump_dec_i(dec_i.jump_dec),
		.match_i, .wb_i, .load_stall_o, .jr_stall_o
	);

	operand_fwd i_operand_fwd (
		.match_i,
		.we_wb_i(wb_i.we_wb),
		.alu_we_fw_i(wb_i.alu_we_fw),
		.sel_o(fw_sel_o)
	);

endmodule

/* source/ctrl_config.svh */
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// widths of the control words.
`define CTRL_STATE_W 4
`define CAUSE_W 6
`define IRQ_ID_W 5
`define REG_ADDR_W 6
`define PC_MUX_W 3
`define FW_SEL_W 2

// machine trap cause codes.
`define EXC_CODE_ILLEGAL 6'h02
`define EXC_CODE_BREAKPOINT 6'h03
`define EXC_CODE_ECALL_UMODE 6'h08
`define EXC_CODE_ECALL_MMODE 6'h0b

// privilege levels as seen on priv_lvl_i.
`define PRIV_LVL_U 2'b00
`define PRIV_LVL_M 2'b11

`endif

/* source/ctrl_fsm.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module ctrl_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   fetch_enable_i,
	input  logic                   instr_valid_i,
	input  logic                   id_ready_i,
	input  logic                   ex_valid_i,
	input  logic                   branch_taken_ex_i,
	input  ctrl_pkg::decode_info_t dec_i,
	input  logic                   irq_i,
	input  logic                   irq_req_i,
	input  logic                   irq_sec_i,
	input  logic [`IRQ_ID_W-1:0]   irq_id_i,
	input  logic                   m_ie_i,
	input  logic                   u_ie_i,
	input  logic [1:0]             priv_lvl_i,
	input  logic                   load_stall_i,
	input  logic                   jr_stall_i,
	output logic                   instr_req_o,
	output logic                   is_decoding_o,
	output logic                   deassert_we_o,
	output logic                   halt_if_o,
	output logic                   halt_id_o,
	output logic                   pc_set_o,
	output ctrl_pkg::pc_mux_e      pc_mux_o,
	output ctrl_pkg::trap_ctrl_t   trap_o,
	output logic                   irq_ack_o,
	output logic [`IRQ_ID_W-1:0]   irq_id_o,
	output logic                   exc_kill_o
);
	import ctrl_pkg::*;

	ctrl_state_e state_q, state_d;
	logic jump_done_q, jump_done;
	logic irq_flush_q, irq_flush_n; // decode the held instr after a dropped irq.
	logic irq_enable;
	logic jump_in_dec;
	logic [`CAUSE_W-1:0] ecall_code;

	assign irq_enable = ((u_ie_i | irq_sec_i) & (priv_lvl_i == `PRIV_LVL_U)) |
		(m_ie_i & (priv_lvl_i == `PRIV_LVL_M));
	assign jump_in_dec = (dec_i.jump_dec == JAL) || (dec_i.jump_dec == JALR);
	assign ecall_code = (priv_lvl_i == `PRIV_LVL_U) ? `EXC_CODE_ECALL_UMODE : `EXC_CODE_ECALL_MMODE;
	assign irq_id_o = irq_id_i;
	assign deassert_we_o = ~is_decoding_o | dec_i.illegal | load_stall_i | jr_stall_i;

	always_comb begin
		state_d = state_q;
		jump_done = jump_done_q;
		irq_flush_n = 1'b0;
		instr_req_o = 1'b1;
		is_decoding_o = 1'b0;
		halt_if_o = 1'b0;
		halt_id_o = 1'b0;
		pc_set_o = 1'b0;
		pc_mux_o = PC_BOOT;
		trap_o = '0;
		irq_ack_o = 1'b0;
		exc_kill_o = 1'b0;
		case (state_q)
			RESET: begin
				instr_req_o = 1'b0;
				if (fetch_enable_i)
					state_d = BOOT_SET;
			end
			BOOT_SET: begin
				pc_set_o = 1'b1;
				state_d = FIRST_FETCH;
			end
			FIRST_FETCH: begin
				if (id_ready_i)
					state_d = DECODE;
				if (irq_req_i && irq_enable) begin
					halt_if_o = 1'b1;
					halt_id_o = 1'b1;
					state_d = IRQ_TAKEN_IF;
				end
			end
			DECODE: begin
				if (branch_taken_ex_i) begin
					pc_mux_o = PC_BRANCH;
					pc_set_o = 1'b1;
				end else if (instr_valid_i || irq_flush_q) begin
					is_decoding_o = 1'b1;
					halt_if_o = (dec_i.jump_id == COND); // no fetch past a branch in id.
					if (irq_req_i && irq_enable) begin
						halt_if_o = 1'b1;
						halt_id_o = 1'b1;
						state_d = IRQ_FLUSH;
					end else if (dec_i.illegal) begin
						halt_if_o = 1'b1;
						halt_id_o = 1'b1;
						trap_o.save_id = 1'b1;
						trap_o.save_cause = 1'b1;
						trap_o.cause.exc = `EXC_CODE_ILLEGAL;
						state_d = FLUSH_EX;
					end else if (jump_in_dec) begin
						pc_mux_o = PC_JUMP;
						if (!jr_stall_i && !jump_done_q) begin
							pc_set_o = 1'b1; // once per jump.
							jump_done = 1'b1;
						end
					end else if (dec_i.ebrk || dec_i.ecall) begin
						halt_if_o = 1'b1;
						halt_id_o = 1'b1;
						trap_o.save_id = 1'b1;
						trap_o.save_cause = 1'b1;
						trap_o.cause.exc = dec_i.ebrk ? `EXC_CODE_BREAKPOINT : ecall_code;
						state_d = FLUSH_EX;
					end else if (dec_i.mret) begin
						halt_if_o = 1'b1;
						halt_id_o = 1'b1;
						state_d = FLUSH_EX;
					end
				end
			end
			FLUSH_EX: begin
				halt_if_o = 1'b1;
				halt_id_o = 1'b1;
				if (ex_valid_i)
					state_d = FLUSH_WB;
			end
			FLUSH_WB: begin
				halt_if_o = 1'b1;
				halt_id_o = 1'b1;
				state_d = DECODE;
				if (dec_i.mret) begin
					trap_o.restore_mret = 1'b1;
					state_d = XRET_JUMP;
				end else begin
					pc_set_o = 1'b1;
					pc_mux_o = PC_EXCEPTION;
					trap_o.exc_pc = EXC_PC_EXCEPTION;
				end
			end
			XRET_JUMP: begin
				pc_set_o = 1'b1;
				pc_mux_o = PC_MRET;
				state_d = DECODE;
			end
			IRQ_FLUSH: begin
				halt_if_o = 1'b1;
				halt_id_o = 1'b1;
				if (irq_i && irq_enable) begin
					state_d = IRQ_TAKEN_ID;
				end else begin
					exc_kill_o = 1'b1;
					irq_flush_n = 1'b1;
					state_d = DECODE;
				end
			end
			IRQ_TAKEN_IF, IRQ_TAKEN_ID: begin
				pc_set_o = 1'b1;
				pc_mux_o = PC_EXCEPTION;
				irq_ack_o = 1'b1;
				trap_o.save_if = (state_q == IRQ_TAKEN_IF);
				trap_o.save_id = (state_q == IRQ_TAKEN_ID);
				trap_o.save_cause = 1'b1;
				trap_o.irq_sec = irq_sec_i;
				trap_o.exc_pc = EXC_PC_IRQ;
				trap_o.cause.irq.flag = 1'b1;
				trap_o.cause.irq.id = irq_id_i;
				state_d = DECODE;
			end
			default: begin
				instr_req_o = 1'b0;
				state_d = RESET;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= RESET;
			jump_done_q <= 1'b0;
			irq_flush_q <= 1'b0;
		end else begin
			state_q <= state_d;
			jump_done_q <= jump_done & ~id_ready_i; // held until id accepts.
			irq_flush_q <= irq_flush_n;
		end
	end

endmodule

/* source/ctrl_pkg.sv */
`include "ctrl_config.svh"

package ctrl_pkg;

	typedef enum logic [`CTRL_STATE_W-1:0] {
		RESET, BOOT_SET, FIRST_FETCH, DECODE, IRQ_TAKEN_IF,
		IRQ_FLUSH, IRQ_TAKEN_ID, FLUSH_EX, FLUSH_WB, XRET_JUMP
	} ctrl_state_e;

	typedef enum logic [`PC_MUX_W-1:0] {
		PC_BOOT = 3'd0, PC_JUMP = 3'd2, PC_BRANCH = 3'd3,
		PC_EXCEPTION = 3'd4, PC_MRET = 3'd5
	} pc_mux_e;

	typedef enum logic {EXC_PC_EXCEPTION = 1'b0, EXC_PC_IRQ = 1'b1} exc_pc_e;

	typedef enum logic [`FW_SEL_W-1:0] {
		SEL_REGFILE = 2'd0, SEL_FW_EX = 2'd1, SEL_FW_WB = 2'd2
	} fw_sel_e;

	typedef enum logic [1:0] {NONE = 2'd0, JAL = 2'd1, JALR = 2'd2, COND = 2'd3} jump_kind_e;

	// mcause as written on save_cause; interrupts set the top bit.
	typedef union packed {
		struct packed {
			logic flag;
			logic [`IRQ_ID_W-1:0] id;
		} irq;
		logic [`CAUSE_W-1:0] exc;
	} cause_u;

	typedef struct packed {
		logic illegal, ecall, ebrk, mret;
		jump_kind_e jump_dec; // straight from the decoder.
		jump_kind_e jump_id;
	} decode_info_t;

	typedef struct packed {
		logic ex_is_a, ex_is_b, ex_is_c;
		logic wb_is_a, wb_is_b, wb_is_c;
		logic alu_is_a, alu_is_b, alu_is_c;
	} hazard_match_t;

	typedef struct packed {
		logic data_req_ex;
		logic we_id, we_ex, we_wb, alu_we_fw;
		logic wb_ready;
		logic [`REG_ADDR_W-1:0] waddr_ex;
		logic [`REG_ADDR_W-1:0] waddr_id;
	} wb_state_t;

	typedef struct packed {
		logic save_if, save_id, save_cause;
		logic irq_sec;
		logic restore_mret;
		exc_pc_e exc_pc;
		cause_u cause;
	} trap_ctrl_t;

	typedef struct packed {
		fw_sel_e a, b, c;
	} fw_sels_t;

endpackage

/* source/hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
	input  logic                    is_decoding_i,
	input  ctrl_pkg::jump_kind_e    jump_dec_i,
	input  ctrl_pkg::hazard_match_t match_i,
	input  ctrl_pkg::wb_state_t     wb_i,
	output logic                    load_stall_o,
	output logic                    jr_stall_o
);
	import ctrl_pkg::*;

	logic load_pending;
	logic src_match;
	logic waw_match;
	logic jr_dep;

	// a load in ex, or a write stuck in wb, is not yet forwardable.
	assign load_pending = (wb_i.data_req_ex & wb_i.we_ex) |
		(~wb_i.wb_ready & wb_i.we_wb);

	assign src_match = match_i.ex_is_a | match_i.ex_is_b | match_i.ex_is_c;

	// decoding instr targets the same register as ex.
	assign waw_match = is_decoding_i & wb_i.we_id & (wb_i.waddr_ex == wb_i.waddr_id);

	assign load_stall_o = load_pending & (src_match | waw_match);

	// jalr target must come from a settled register.
	assign jr_dep = (wb_i.we_wb & match_i.wb_is_a) |
		(wb_i.we_ex & match_i.ex_is_a) |
		(wb_i.alu_we_fw & match_i.alu_is_a);

	assign jr_stall_o = (jump_dec_i == JALR) & jr_dep;

endmodule

/* source/operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd (
	input  ctrl_pkg::hazard_match_t match_i,
	input  logic                    we_wb_i,
	input  logic                    alu_we_fw_i,
	output ctrl_pkg::fw_sels_t      sel_o
);
	import ctrl_pkg::*;

	// ex result is newer than wb, so it wins.
	function automatic fw_sel_e pick_src(input logic wb_hit, input logic alu_hit);
		fw_sel_e sel;
		sel = SEL_REGFILE;
		if (we_wb_i && wb_hit)
			sel = SEL_FW_WB;
		if (alu_we_fw_i && alu_hit)
			sel = SEL_FW_EX;
		return sel;
	endfunction

	always_comb begin
		sel_o.a = pick_src(match_i.wb_is_a, match_i.alu_is_a);
		sel_o.b = pick_src(match_i.wb_is_b, match_i.alu_is_b);
		sel_o.c = pick_src(match_i.wb_is_c, match_i.alu_is_c);
	end

endmodule

/* testbench/ctrl_trace.txt */
# test, inputs (en vld rdy exv br dec irq req sec id mie uie prv match wb)
# then expected outputs (set mux ack kill trap lds jrs fw), every field in hex
1 1 0 0 0 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
1 1 0 0 0 0 00 0 0 0 00 0 0 3 000 01042  1 0 0 0 000 0 0 00
1 1 0 0 0 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
1 1 0 1 0 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
2 1 1 0 0 0 04 0 0 0 00 0 0 3 000 01042  1 2 0 0 000 0 0 00
2 1 1 0 0 0 04 0 0 0 00 0 0 3 000 01042  0 2 0 0 000 0 0 00
2 1 1 0 0 0 04 0 0 0 00 0 0 3 000 01042  0 2 0 0 000 0 0 00
2 1 1 1 0 0 04 0 0 0 00 0 0 3 000 01042  0 2 0 0 000 0 0 00
2 1 1 1 0 1 00 0 0 0 00 0 0 3 000 01042  1 3 0 0 000 0 0 00
2 1 1 0 0 0 08 0 0 0 00 0 0 3 100 09042  0 2 0 0 000 0 1 00
2 1 1 0 0 0 08 0 0 0 00 0 0 3 100 09042  0 2 0 0 000 0 1 00
2 1 1 1 0 0 08 0 0 0 00 0 0 3 000 01042  1 2 0 0 000 0 0 00
3 1 1 1 0 0 80 0 0 0 00 0 0 3 000 01042  0 0 0 0 602 0 0 00
3 1 1 1 0 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
3 1 1 1 1 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
3 1 1 1 0 0 00 0 0 0 00 0 0 3 000 01042  1 4 0 0 000 0 0 00
3 1 1 1 0 0 40 0 0 0 00 0 0 0 000 01042  0 0 0 0 608 0 0 00
3 1 1 1 1 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
3 1 1 1 0 0 00 0 0 0 00 0 0 3 000 01042  1 4 0 0 000 0 0 00
3 1 1 1 0 0 40 0 0 0 00 0 0 3 000 01042  0 0 0 0 60b 0 0 00
3 1 1 1 1 0 00 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
3 1 1 1 0 0 00 0 0 0 00 0 0 3 000 01042  1 4 0 0 000 0 0 00
4 1 1 1 0 0 00 1 1 0 07 1 0 3 000 01042  0 0 0 0 000 0 0 00
4 1 1 1 0 0 00 1 1 0 07 1 0 3 000 01042  0 0 0 0 000 0 0 00
4 1 1 1 0 0 00 0 0 0 07 1 0 3 000 01042  1 4 1 0 667 0 0 00
4 1 1 1 0 0 00 1 1 0 03 1 0 3 000 01042  0 0 0 0 000 0 0 00
4 1 1 1 0 0 00 0 0 0 03 1 0 3 000 01042  0 0 0 1 000 0 0 00
4 1 1 1 0 0 00 1 1 0 03 0 0 3 000 01042  0 0 0 0 000 0 0 00
4 1 1 1 0 0 00 1 1 0 03 0 0 3 000 01042  0 0 0 0 000 0 0 00
5 1 1 1 0 0 10 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
5 1 1 1 1 0 10 0 0 0 00 0 0 3 000 01042  0 0 0 0 000 0 0 00
5 1 1 1 0 0 10 0 0 0 00 0 0 3 000 01042  0 0 0 0 080 0 0 00
5 1 1 1 0 0 00 0 0 0 00 0 0 3 000 01042  1 5 0 0 000 0 0 00
6 1 1 1 0 0 00 0 0 0 00 0 0 3 080 29042  0 0 0 0 000 1 0 00
6 1 1 1 0 0 00 0 0 0 00 0 0 3 012 07042  0 0 0 0 000 0 0 04
6 1 1 1 0 0 00 0 0 0 00 0 0 3 010 07042  0 0 0 0 000 0 0 08
6 1 1 1 0 0 00 0 0 0 00 0 0 3 000 39145  0 0 0 0 000 1 0 00

/* testbench/tb_core_ctrl.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module tb_core_ctrl;
	import ctrl_pkg::*;

	localparam int RESET_TIMEOUT = 20;
	localparam int MAX_LINES = 1000;

	logic clk;
	logic rst_n;
	logic fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i, branch_taken_ex_i;
	decode_info_t dec_i;
	logic irq_i, irq_req_i, irq_sec_i;
	logic [`IRQ_ID_W-1:0] irq_id_i;
	logic m_ie_i, u_ie_i;
	logic [1:0] priv_lvl_i;
	hazard_match_t match_i;
	wb_state_t wb_i;
	logic instr_req_o, is_decoding_o, deassert_we_o, halt_if_o, halt_id_o;
	logic pc_set_o;
	pc_mux_e pc_mux_o;
	trap_ctrl_t trap_o;
	logic irq_ack_o;
	logic [`IRQ_ID_W-1:0] irq_id_o;
	logic exc_kill_o, load_stall_o, jr_stall_o;
	fw_sels_t fw_sel_o;

	logic [31:0] col [24]; // one trace line with the test number first.
	int cur_test;
	int test_errs;
	int test_cycles;
	int tests_passed;
	int tests_failed;
	int setup_errs;
	logic booted;

	core_ctrl i_core_ctrl (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#5 rst_n = 1'b1;
	end

	task automatic init_inputs();
		fetch_enable_i = 1'b0;
		instr_valid_i = 1'b0;
		id_ready_i = 1'b0;
		ex_valid_i = 1'b0;
		branch_taken_ex_i = 1'b0;
		dec_i = '0;
		irq_i = 1'b0;
		irq_req_i = 1'b0;
		irq_sec_i = 1'b0;
		irq_id_i = '0;
		m_ie_i = 1'b0;
		u_ie_i = 1'b0;
		priv_lvl_i = 2'b00;
		match_i = '0;
		wb_i = '0;
	endtask

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: test %0d %s is %h, expected %h", $time, cur_test, name,
				got, exp);
			test_errs++;
		end
	endtask

	// outputs without a trace column follow from the expected ones.
	task automatic check_side_outputs();
		trap_ctrl_t exp_trap;
		logic exp_set;
		logic exp_ack;
		logic [`PC_MUX_W-1:0] exp_mux;
		logic trap_seen;
		logic redirect;
		logic flushing;
		exp_trap = col[20][$bits(trap_ctrl_t)-1:0];
		exp_set = col[16][0];
		exp_ack = col[18][0];
		exp_mux = col[17][`PC_MUX_W-1:0];
		trap_seen = exp_trap.save_id & ~exp_ack; // trap found in decode.
		redirect = exp_set & (exp_mux != PC_JUMP) & (exp_mux != PC_BRANCH);
		flushing = trap_seen | exp_trap.restore_mret | col[19][0] |
			(exp_set & ~exp_ack & (exp_mux == PC_EXCEPTION));
		if (exp_set && exp_mux == PC_BOOT)
			booted = 1'b1;
		check_field("instr_req", 32'(instr_req_o), 32'(booted));
		if (exp_ack)
			check_field("irq_id", 32'(irq_id_o), 32'(exp_trap.cause.irq.id));
		if (trap_seen)
			check_field("is_decoding", 32'(is_decoding_o), 32'd1);
		if (redirect)
			check_field("is_decoding", 32'(is_decoding_o), 32'd0);
		if (redirect || dec_i.illegal || col[21][0] || col[22][0])
			check_field("deassert_we", 32'(deassert_we_o), 32'd1);
		if (flushing) begin
			check_field("halt_if", 32'(halt_if_o), 32'd1);
			check_field("halt_id", 32'(halt_id_o), 32'd1);
		end
	endtask

	task automatic run_cycle();
		@(posedge clk);
		#5;
		fetch_enable_i = col[1][0];
		instr_valid_i = col[2][0];
		id_ready_i = col[3][0];
		ex_valid_i = col[4][0];
		branch_taken_ex_i = col[5][0];
		dec_i = col[6][$bits(decode_info_t)-1:0];
		irq_i = col[7][0];
		irq_req_i = col[8][0];
		irq_sec_i = col[9][0];
		irq_id_i = col[10][`IRQ_ID_W-1:0];
		m_ie_i = col[11][0];
		u_ie_i = col[12][0];
		priv_lvl_i = col[13][1:0];
		match_i = col[14][$bits(hazard_match_t)-1:0];
		wb_i = col[15][$bits(wb_state_t)-1:0];
		#90; // just before the next edge.
		check_field("pc_set", 32'(pc_set_o), col[16]);
		check_field("pc_mux", 32'(pc_mux_o), col[17]);
		check_field("irq_ack", 32'(irq_ack_o), col[18]);
		check_field("exc_kill", 32'(exc_kill_o), col[19]);
		check_field("trap", 32'(trap_o), col[20]);
		check_field("load_stall", 32'(load_stall_o), col[21]);
		check_field("jr_stall", 32'(jr_stall_o), col[22]);
		check_field("fw_sel", 32'(fw_sel_o), col[23]);
		check_side_outputs();
		test_cycles++;
	endtask

	task automatic close_test();
		if (test_errs == 0) begin
			$display("test %0d: ok after %0d cycles", cur_test, test_cycles);
			tests_passed++;
		end else begin
			$display("test %0d: %0d mismatches in %0d cycles", cur_test, test_errs, test_cycles);
			tests_failed++;
		end
	endtask

	task automatic run_trace();
		int fd;
		int n_read;
		int line_no;
		string line;
		fd = $fopen("testbench/ctrl_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file testbench/ctrl_trace.txt");
			setup_errs++;
			return;
		end
		line_no = 0;
		while (!$feof(fd) && line_no < MAX_LINES) begin
			line_no++;
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
				col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
			if (n_read != 24) begin
				$display("trace line %0d holds %0d fields instead of 24", line_no, n_read);
				setup_errs++;
				continue;
			end
			if (col[0] != cur_test) begin // a new test begins.
				if (cur_test >= 0)
					close_test();
				cur_test = col[0];
				test_errs = 0;
				test_cycles = 0;
			end
			run_cycle();
		end
		if (cur_test >= 0)
			close_test();
		$fclose(fd);
	endtask

	initial begin
		int wait_cycles;
		init_inputs();
		cur_test = -1;
		tests_passed = 0;
		tests_failed = 0;
		setup_errs = 0;
		booted = 1'b0;
		wait_cycles = 0;
		while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was still active after %0d cycles", RESET_TIMEOUT);
			setup_errs++;
		end else begin
			run_trace();
		end
		$display("tests: %0d ok, %0d with mismatches", tests_passed, tests_failed);
		if (tests_failed == 0 && setup_errs == 0 && tests_passed > 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
